// ==== hdl/lolap_perm_pkg.sv ====
`default_nettype none

package lolap_perm_pkg;

    // Permutation state size in bits.
    localparam int state_width = 257;

    // Pi multiplier, taken mod state_width.
    localparam int pi_factor = 121;

    // Theta taps, added to the bit index mod state_width.
    localparam int theta_tap_near = 3;
    localparam int theta_tap_far  = 10;

    // Round constant is a single inverted bit.
    localparam int iota_bit = 0;

    typedef logic [state_width-1:0] state_t;

endpackage

`default_nettype wire

// ==== hdl/lolap_ctrl_pkg.sv ====
`default_nettype none

package lolap_ctrl_pkg;

    // Largest round count accepted per job.
    localparam int max_rounds = 16;

    // Counter width covers 0 to max_rounds.
    localparam int round_count_width = $clog2(max_rounds + 1);

    typedef logic [round_count_width-1:0] round_count_t;

    // Controller FSM states.
    typedef enum logic [1:0] {
        idle = 2'd0,
        run  = 2'd1,
        done = 2'd2
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hdl/lolap_round.sv ====
`timescale 1ns/100ps
`default_nettype none

module lolap_round (
    input  lolap_perm_pkg::state_t round_in,
    output lolap_perm_pkg::state_t round_out
);

    import lolap_perm_pkg::*;

    state_t after_pi;
    state_t after_theta;

    genvar j;
    genvar i;
    genvar k;

    // Pi step. Bit j takes bit (pi_factor * j) mod state_width.
    generate
        for (j = 0; j < state_width; j = j + 1) begin : pi_step
            localparam int src = (pi_factor * j) % state_width;
            assign after_pi[j] = round_in[src];
        end
    endgenerate

    // Theta with iota.
    generate
        for (i = 0; i < state_width; i = i + 1) begin : theta_step
            localparam int tap_near = (i + theta_tap_near) % state_width;
            localparam int tap_far  = (i + theta_tap_far) % state_width;

            logic mix;

            assign mix = after_pi[i] ^ after_pi[tap_near] ^ after_pi[tap_far];

            if (i == iota_bit) begin : iota
                assign after_theta[i] = ~mix;
            end else begin : plain
                assign after_theta[i] = mix;
            end
        end
    endgenerate

    // Chi step, wraps around the top of the state.
    generate
        for (k = 0; k < state_width; k = k + 1) begin : chi_step
            localparam int next1 = (k + 1) % state_width;
            localparam int next2 = (k + 2) % state_width;

            assign round_out[k] = after_theta[k] ^
                                  (~after_theta[next1] & after_theta[next2]);
        end
    endgenerate

endmodule

`default_nettype wire

// ==== hdl/lolap_state.sv ====
`timescale 1ns/100ps
`default_nettype none

module lolap_state (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load,
    input  logic                   advance,
    input  lolap_perm_pkg::state_t state_in,
    output lolap_perm_pkg::state_t state_out
);

    import lolap_perm_pkg::*;

    state_t state_q;
    state_t round_result;

    // One round per clock, fed from the register.
    lolap_round round0 (
        .round_in  (state_q),
        .round_out (round_result)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= '0;
        end else if (load) begin
            state_q <= state_in;        // New job.
        end else if (advance) begin
            state_q <= round_result;
        end
    end

    assign state_out = state_q;

    // Controller never asks for a load and a round in the same cycle.
    a_load_advance_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(load && advance)
    ) else $error("load and advance high together");

endmodule

`default_nettype wire

// ==== hdl/lolap_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module lolap_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req,
    input  lolap_ctrl_pkg::round_count_t rounds,
    output logic                         ack,
    output logic                         load,
    output logic                         advance
);

    import lolap_ctrl_pkg::*;

    ctrl_state_t  state;
    round_count_t count;        // Rounds still to apply.
    logic         last_round;
    logic         accept;

    assign accept     = (state == idle) && req;
    assign last_round = (count == round_count_t'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            count   <= '0;
            load    <= 1'b0;
            advance <= 1'b0;
            ack     <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (req) begin
                        state <= run;
                        load  <= 1'b1;
                        count <= rounds;
                    end
                end

                run: begin
                    if (load) begin
                        // State is loaded on this edge, rounds start next.
                        load    <= 1'b0;
                        advance <= 1'b1;
                    end else if (advance) begin
                        count <= count - round_count_t'(1);
                        if (last_round) begin
                            advance <= 1'b0;
                            ack     <= 1'b1;    // Result valid after this edge.
                            state   <= done;
                        end
                    end
                end

                done: begin
                    // Hold the result until the requester lets go.
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= idle;
                    end
                end

                default: begin
                    state   <= idle;
                    load    <= 1'b0;
                    advance <= 1'b0;
                    ack     <= 1'b0;
                end
            endcase
        end
    end

    // Round count must be in range when a job is taken.
    a_rounds_range: assert property (
        @(posedge clk) disable iff (rst)
        accept |-> (rounds >= round_count_t'(1)) &&
                   (rounds <= round_count_t'(max_rounds))
    ) else $error("rounds out of range at accept: %0d", rounds);

    // Four-phase rule, ack held while req stays high.
    a_ack_hold: assert property (
        @(posedge clk) disable iff (rst)
        (ack && req) |=> ack
    ) else $error("ack dropped while req high");

    // And ack only rises for a pending request.
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (rst)
        (!ack && !req) |=> !ack
    ) else $error("ack raised without req");

endmodule

`default_nettype wire

// ==== hdl/lolap_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lolap_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req,
    input  lolap_ctrl_pkg::round_count_t rounds,
    input  lolap_perm_pkg::state_t       state_in,
    output logic                         ack,
    output lolap_perm_pkg::state_t       state_out
);

    logic load;
    logic advance;

    // Handshake and round sequencing.
    lolap_ctrl ctrl0 (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .rounds  (rounds),
        .ack     (ack),
        .load    (load),
        .advance (advance)
    );

    // State register with the round logic.
    lolap_state state0 (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .advance   (advance),
        .state_in  (state_in),
        .state_out (state_out)
    );

endmodule

`default_nettype wire

// ==== test/lolap_tb_model.svh ====
`ifndef LOLAP_TB_MODEL_SVH
`define LOLAP_TB_MODEL_SVH

// Row kinds for the stimulus table.
localparam int num_tests   = 10;
localparam int kind_zero   = 0;
localparam int kind_random = 1;
localparam int kind_chain  = 2;     // Starts from the previous job's result.

string  tab_name   [num_tests];
int     tab_kind   [num_tests];
state_t tab_start  [num_tests];
int     tab_rounds [num_tests];
int     tab_hold   [num_tests];     // Extra cycles req stays high after ack.

// One round built from the pi, theta with iota, and chi rules.
function automatic state_t round_model(input state_t s);
    state_t p;
    state_t t;
    state_t c;
    int     src;
    src = 0;
    for (int j = 0; j < state_width; j++) begin
        p[j] = s[src];
        src = src + pi_factor;      // Next multiple of 121, mod 257.
        if (src >= state_width) begin
            src = src - state_width;
        end
    end
    for (int i = 0; i < state_width; i++) begin
        t[i] = p[i] ^ p[(i + theta_tap_near) % state_width]
                    ^ p[(i + theta_tap_far) % state_width];
    end
    t[iota_bit] = ~t[iota_bit];
    for (int i = 0; i < state_width; i++) begin
        c[i] = t[i] ^ (~t[(i + 1) % state_width] & t[(i + 2) % state_width]);
    end
    return c;
endfunction

function automatic state_t permute_model(input state_t s, input int n);
    state_t r;
    r = s;
    for (int k = 0; k < n; k++) begin
        r = round_model(r);
    end
    return r;
endfunction

function automatic state_t random_state();
    logic [287:0] wide;
    for (int w = 0; w < 9; w++) begin
        wide[w*32 +: 32] = $random(seed);
    end
    return wide[state_width-1:0];
endfunction

function automatic void set_entry(input int idx, input string name, input int kind,
                                  input int n, input int hold);
    tab_name[idx]   = name;
    tab_kind[idx]   = kind;
    tab_rounds[idx] = n;
    tab_hold[idx]   = hold;
    tab_start[idx]  = (kind == kind_random) ? random_state() : '0;
endfunction

task automatic fill_table();
    //        row name              kind         rounds hold
    set_entry(0, "zero_one_round",  kind_zero,   1,     0);
    set_entry(1, "rand_r1",         kind_random, 1,     0);
    set_entry(2, "rand_r5",         kind_random, 5,     0);
    set_entry(3, "rand_r16",        kind_random, 16,    0);
    set_entry(4, "rand_r9_hold",    kind_random, 9,     4);
    set_entry(5, "rand_r3",         kind_random, 3,     0);
    set_entry(6, "rand_r12_hold",   kind_random, 12,    1);
    set_entry(7, "chain_first_r7",  kind_random, 7,     0);
    set_entry(8, "chain_second_r11", kind_chain, 11,    0);
    set_entry(9, "rand_r2",         kind_random, 2,     2);
endtask

`endif

// ==== test/lolap_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lolap_tb;

    import lolap_perm_pkg::*;
    import lolap_ctrl_pkg::*;

    logic         clk;
    logic         rst;
    logic         req;
    round_count_t rounds;
    state_t       state_in;
    logic         ack;
    state_t       state_out;

    int     seed;
    bit     table_ready;
    int     tests_run;
    int     tests_failed;
    int     check_errors;
    state_t last_result;
    state_t chain_base;     // Start state of the current chain of jobs.
    int     chain_rounds;

    `include "lolap_tb_model.svh"

    lolap_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .rounds    (rounds),
        .state_in  (state_in),
        .ack       (ack),
        .state_out (state_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (check_errors == errs_before) begin
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed", name);
        end
    endtask

    // One four-phase transaction for table row idx.
    task automatic run_job(input int idx);
        state_t start;
        state_t expected;
        state_t held;
        int     edges;
        int     errs;
        bit     acked;
        errs = check_errors;
        if (tab_kind[idx] == kind_chain) begin
            start        = last_result;
            chain_rounds = chain_rounds + tab_rounds[idx];
        end else begin
            start        = tab_start[idx];
            chain_base   = start;
            chain_rounds = tab_rounds[idx];
        end
        expected = permute_model(chain_base, chain_rounds);

        req      = 1'b1;
        rounds   = round_count_t'(tab_rounds[idx]);
        state_in = start;
        edges    = 0;
        // First edge counted is the accepting one.
        while (ack !== 1'b1 && edges < max_rounds + 4) begin
            @(posedge clk);
            #1;
            edges++;
        end
        acked = (ack === 1'b1);
        if (!acked) begin
            check_errors++;
            $display("Test %s: ack never rose within %0d edges", tab_name[idx], edges);
        end else begin
            if (edges - 1 != tab_rounds[idx] + 1) begin
                check_errors++;
                $display("Fail %s ack edges: expected %0d actual %0d",
                         tab_name[idx], tab_rounds[idx] + 1, edges - 1);
            end
            if (state_out !== expected) begin
                check_errors++;
                $display("Fail %s state: expected %h actual %h",
                         tab_name[idx], expected, state_out);
            end
            // Iota leaves bit 0 set after one round of the zero state.
            if (tab_kind[idx] == kind_zero && state_out[iota_bit] !== 1'b1) begin
                check_errors++;
                $display("Fail %s bit0: expected 1 actual %b",
                         tab_name[idx], state_out[iota_bit]);
            end
        end
        held        = state_out;
        last_result = state_out;

        // Result must hold under back-pressure.
        repeat (tab_hold[idx]) begin
            @(posedge clk);
            #1;
            if (ack !== 1'b1) begin
                check_errors++;
                $display("Test %s: ack dropped while req was still high", tab_name[idx]);
            end
            if (state_out !== held) begin
                check_errors++;
                $display("Fail %s held state: expected %h actual %h",
                         tab_name[idx], held, state_out);
            end
        end

        req   = 1'b0;
        edges = 0;
        while (ack === 1'b1 && edges < 4) begin
            @(posedge clk);
            #1;
            edges++;
        end
        if (ack !== 1'b0) begin
            check_errors++;
            $display("Test %s: ack stayed high after req dropped", tab_name[idx]);
        end else if (acked && edges != 1) begin
            check_errors++;
            $display("Fail %s ack fall edges: expected 1 actual %0d", tab_name[idx], edges);
        end
        report_test(tab_name[idx], errs);
    endtask

    initial begin : watchdog
        int limit_cycles;
        wait (table_ready);
        limit_cycles = 20;      // Reset and margin.
        for (int t = 0; t < num_tests; t++) begin
            limit_cycles = limit_cycles + tab_rounds[t] + tab_hold[t] + 6;
        end
        #(limit_cycles * 10);
        $display("Watchdog: run did not finish within %0d cycles", limit_cycles);
        $display("Something failed");
        $finish;
    end

    initial begin : main
        int errs;
        rst          = 1'b1;
        req          = 1'b0;
        rounds       = '0;
        state_in     = '0;
        seed         = 59;
        tests_run    = 0;
        tests_failed = 0;
        check_errors = 0;
        chain_rounds = 0;
        chain_base   = '0;
        last_result  = '0;
        fill_table();
        table_ready = 1'b1;

        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        @(posedge clk);
        #1;

        errs = check_errors;
        if (ack !== 1'b0) begin
            check_errors++;
            $display("Fail reset_values ack: expected 0 actual %b", ack);
        end
        if (state_out !== '0) begin
            check_errors++;
            $display("Fail reset_values state: expected %h actual %h", state_t'(0), state_out);
        end
        report_test("reset_values", errs);

        for (int t = 0; t < num_tests; t++) begin
            run_job(t);
        end

        $display("Tests: %0d run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && check_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+test
hdl/lolap_perm_pkg.sv
hdl/lolap_ctrl_pkg.sv
hdl/lolap_round.sv
hdl/lolap_state.sv
hdl/lolap_ctrl.sv
hdl/lolap_top.sv
test/lolap_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the lolap testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module lolap_tb \
    -Mdir obj_dir \
    -f flist.f

./obj_dir/Vlolap_tb | tee sim.log

if grep -qx "Everything OK" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
